/* common/src_pkg.sv */
package src_pkg;

    ////////////////////////////////////////////////////////////
    // widths
    ////////////////////////////////////////////////////////////

    localparam int SAMPLE_W = 24;                  // audio sample, two's complement
    localparam int COEF_W   = 16;                  // weight, holds 2^PERIOD_LOG2 up to 14
    localparam int PROD_W   = SAMPLE_W + COEF_W;   // 40 bit product
    localparam int ACC_W    = PROD_W + 1;          // one guard bit for the two-tap sum

    ////////////////////////////////////////////////////////////
    // data types
    ////////////////////////////////////////////////////////////

    // signed stereo sample, one per channel
    typedef logic signed [SAMPLE_W-1:0] sample_t;

    // unsigned interpolation weight / phase count
    typedef logic [COEF_W-1:0] coef_t;

    typedef logic signed [PROD_W-1:0] prod_t;      // sample * weight
    typedef logic signed [ACC_W-1:0]  acc_t;       // new tap + old tap

    ////////////////////////////////////////////////////////////
    // engine sequencing
    ////////////////////////////////////////////////////////////

    // one pass per output tick, back to idle after the sum
    typedef enum logic [2:0] {
        IDLE     = 3'd0,    // waiting for tick
        LOAD_NEW = 3'd1,    // newest sample into multiplier
        LOAD_OLD = 3'd2,    // older sample into multiplier
        TAKE_NEW = 3'd3,    // newest product leaves pipe
        TAKE_OLD = 3'd4,    // older product leaves pipe
        SUM      = 3'd5     // add the two taps
    } engine_state_t;

endpackage

/* rtl/sample_capture.sv */
`timescale 1ns/1ps

module sample_capture #(
    parameter int PERIOD_LOG2 = 9
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             in_strobe,
    input  src_pkg::sample_t l_in,
    input  src_pkg::sample_t r_in,
    input  src_pkg::coef_t   phase_cnt,   // cycles since last output tick
    input  logic             busy,        // engine reading the history
    output src_pkg::sample_t l_new,
    output src_pkg::sample_t l_old,
    output src_pkg::sample_t r_new,
    output src_pkg::sample_t r_old,
    output src_pkg::coef_t   phase_coef   // phase of the newest commit
);

    localparam int unsigned PERIOD = 1 << PERIOD_LOG2;

    // pending slot, filled on every strobe
    logic             pending;
    src_pkg::sample_t l_pend;
    src_pkg::sample_t r_pend;
    src_pkg::coef_t   phase_pend;

    ////////////////////////////////////////////////////////////
    // pending slot
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= 1'b0;
        end else begin
            if (pending && !busy) pending <= 1'b0;   // drained into history
            if (in_strobe)        pending <= 1'b1;   // new strobe wins
        end
    end

    always_ff @(posedge clk) begin
        if (in_strobe) begin
            l_pend     <= l_in;
            r_pend     <= r_in;
            phase_pend <= phase_cnt;   // phase at arrival, not at commit
        end
    end

    ////////////////////////////////////////////////////////////
    // two-sample history
    ////////////////////////////////////////////////////////////

    // starts as silence so the engine never sees X before the first strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            l_new      <= '0;
            l_old      <= '0;
            r_new      <= '0;
            r_old      <= '0;
            phase_coef <= '0;
        end else if (pending && !busy) begin
            l_old      <= l_new;        // shift
            r_old      <= r_new;
            l_new      <= l_pend;
            r_new      <= r_pend;
            phase_coef <= phase_pend;
        end
    end

    // input rate too high: second sample lands before the first drained
    a_no_overrun : assert property (@(posedge clk) disable iff (rst)
        in_strobe |-> !(pending && busy));

    // latched phase must be a legal weight
    a_phase_range : assert property (@(posedge clk) disable iff (rst)
        in_strobe |-> (phase_cnt < PERIOD));

endmodule

/* interp/tap_multiplier.sv */
`timescale 1ns/1ps

module tap_multiplier (
    input  logic             clk,
    input  logic             rst,
    input  logic             en,       // pipe advances only when high
    input  src_pkg::sample_t sample,   // signed
    input  src_pkg::coef_t   coef,     // unsigned weight
    output src_pkg::prod_t   product
);

    src_pkg::prod_t mul_q;   // first stage

    // zero-extend the weight so the multiply stays signed
    logic signed [src_pkg::COEF_W:0] coef_s;

    assign coef_s = $signed({1'b0, coef});

    always_ff @(posedge clk) begin
        if (rst) begin
            mul_q   <= '0;
            product <= '0;
        end else if (en) begin
            mul_q   <= sample * coef_s;   // fits in 40 bits, weight < 2^16
            product <= mul_q;             // second stage
        end
    end

endmodule

/* interp/interp_engine.sv */
`timescale 1ns/1ps

module interp_engine #(
    parameter int PERIOD_LOG2 = 9
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             tick,        // output-rate strobe
    input  src_pkg::sample_t l_new,
    input  src_pkg::sample_t l_old,
    input  src_pkg::sample_t r_new,
    input  src_pkg::sample_t r_old,
    input  src_pkg::coef_t   phase_coef,
    output logic             busy,
    output logic             sum_valid,
    output src_pkg::acc_t    l_sum,
    output src_pkg::acc_t    r_sum
);

    localparam int unsigned PERIOD = 1 << PERIOD_LOG2;

    src_pkg::engine_state_t state;

    // shared multiplier operands
    logic             mult_en;
    src_pkg::coef_t   mult_coef;
    src_pkg::sample_t l_mult_in;
    src_pkg::sample_t r_mult_in;
    src_pkg::prod_t   l_prod;
    src_pkg::prod_t   r_prod;

    // products held until SUM
    src_pkg::prod_t   l_tap_new;
    src_pkg::prod_t   l_tap_old;
    src_pkg::prod_t   r_tap_new;
    src_pkg::prod_t   r_tap_old;

    ////////////////////////////////////////////////////////////
    // sequencer
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= src_pkg::IDLE;
            sum_valid <= 1'b0;
        end else begin
            sum_valid <= 1'b0;
            case (state)
                src_pkg::IDLE:     if (tick) state <= src_pkg::LOAD_NEW;
                src_pkg::LOAD_NEW: state <= src_pkg::LOAD_OLD;
                src_pkg::LOAD_OLD: state <= src_pkg::TAKE_NEW;
                src_pkg::TAKE_NEW: state <= src_pkg::TAKE_OLD;
                src_pkg::TAKE_OLD: state <= src_pkg::SUM;
                src_pkg::SUM: begin
                    state     <= src_pkg::IDLE;
                    sum_valid <= 1'b1;   // one cycle, sums valid with it
                end
                default:           state <= src_pkg::IDLE;
            endcase
        end
    end

    assign busy = (state != src_pkg::IDLE);   // history frozen while high

    // history is read live in the load states, capture has stopped committing
    always_comb begin
        mult_en   = (state == src_pkg::LOAD_NEW) || (state == src_pkg::LOAD_OLD)
                 || (state == src_pkg::TAKE_NEW);   // 2 pushes + 1 flush
        if (state == src_pkg::LOAD_NEW) begin
            mult_coef = src_pkg::coef_t'(PERIOD - phase_coef);   // newest weight
            l_mult_in = l_new;
            r_mult_in = r_new;
        end else begin
            mult_coef = phase_coef;                              // older weight
            l_mult_in = l_old;
            r_mult_in = r_old;
        end
    end

    ////////////////////////////////////////////////////////////
    // multipliers, one per channel
    ////////////////////////////////////////////////////////////

    tap_multiplier l_mult (
        .clk     (clk),
        .rst     (rst),
        .en      (mult_en),
        .sample  (l_mult_in),
        .coef    (mult_coef),
        .product (l_prod)
    );

    tap_multiplier r_mult (
        .clk     (clk),
        .rst     (rst),
        .en      (mult_en),
        .sample  (r_mult_in),
        .coef    (mult_coef),
        .product (r_prod)
    );

    // newest product out in TAKE_NEW, older one in TAKE_OLD
    always_ff @(posedge clk) begin
        case (state)
            src_pkg::TAKE_NEW: begin
                l_tap_new <= l_prod;
                r_tap_new <= r_prod;
            end
            src_pkg::TAKE_OLD: begin
                l_tap_old <= l_prod;
                r_tap_old <= r_prod;
            end
            src_pkg::SUM: begin
                l_sum <= src_pkg::acc_t'(l_tap_new) + src_pkg::acc_t'(l_tap_old);
                r_sum <= src_pkg::acc_t'(r_tap_new) + src_pkg::acc_t'(r_tap_old);
            end
            default: ;
        endcase
    end

    // output period must cover the whole pass
    a_no_retrigger : assert property (@(posedge clk) disable iff (rst)
        tick |-> !busy);

    a_weight_range : assert property (@(posedge clk) disable iff (rst)
        (state == src_pkg::LOAD_NEW) |-> (phase_coef < PERIOD));

endmodule

/* rtl/output_stage.sv */
`timescale 1ns/1ps

module output_stage #(
    parameter int PERIOD_LOG2 = 9
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             run,
    output logic             tick,        // one cycle per output period
    output src_pkg::coef_t   phase_cnt,
    input  logic             sum_valid,
    input  src_pkg::acc_t    l_sum,
    input  src_pkg::acc_t    r_sum,
    output logic             out_valid,
    output src_pkg::sample_t l_out,
    output src_pkg::sample_t r_out
);

    localparam src_pkg::coef_t LAST = src_pkg::coef_t'((1 << PERIOD_LOG2) - 1);
    localparam src_pkg::acc_t  HALF = src_pkg::acc_t'(1) << (PERIOD_LOG2 - 1);

    src_pkg::acc_t l_shift;
    src_pkg::acc_t r_shift;

    ////////////////////////////////////////////////////////////
    // rate divider
    ////////////////////////////////////////////////////////////

    // 49.152 MHz / 512 gives 96 kHz at the default
    always_ff @(posedge clk) begin
        if (rst || !run) begin
            phase_cnt <= '0;   // restart, first tick one full period later
            tick      <= 1'b0;
        end else if (phase_cnt == LAST) begin
            phase_cnt <= '0;
            tick      <= 1'b1;
        end else begin
            phase_cnt <= phase_cnt + 1'b1;
            tick      <= 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////
    // rounding and output registers
    ////////////////////////////////////////////////////////////

    // round half up, then drop the weight scale
    assign l_shift = (l_sum + HALF) >>> PERIOD_LOG2;
    assign r_shift = (r_sum + HALF) >>> PERIOD_LOG2;

    always_ff @(posedge clk) begin
        if (rst) out_valid <= 1'b0;
        else     out_valid <= sum_valid;
    end

    always_ff @(posedge clk) begin
        if (sum_valid) begin
            l_out <= src_pkg::sample_t'(l_shift);   // weights sum to 2^n, no clip
            r_out <= src_pkg::sample_t'(r_shift);
        end
    end

    // upper bits must be pure sign extension
    a_fits_sample : assert property (@(posedge clk) disable iff (rst)
        sum_valid |-> (l_shift == src_pkg::acc_t'(src_pkg::sample_t'(l_shift)))
                   && (r_shift == src_pkg::acc_t'(src_pkg::sample_t'(r_shift))));

endmodule

/* rtl/stereo_interp_top.sv */
`timescale 1ns/1ps

module stereo_interp_top #(
    parameter int PERIOD_LOG2 = 9   // 4..14, output every 2^n cycles
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             run,
    input  logic             in_strobe,   // shared by both channels
    input  src_pkg::sample_t l_in,
    input  src_pkg::sample_t r_in,
    output logic             out_valid,
    output src_pkg::sample_t l_out,
    output src_pkg::sample_t r_out
);

    // output rate
    logic             tick;
    src_pkg::coef_t   phase_cnt;

    // history into the engine
    logic             busy;
    src_pkg::sample_t l_new;
    src_pkg::sample_t l_old;
    src_pkg::sample_t r_new;
    src_pkg::sample_t r_old;
    src_pkg::coef_t   phase_coef;

    // engine result
    logic             sum_valid;
    src_pkg::acc_t    l_sum;
    src_pkg::acc_t    r_sum;

    ////////////////////////////////////////////////////////////
    // input side
    ////////////////////////////////////////////////////////////

    sample_capture #(
        .PERIOD_LOG2 (PERIOD_LOG2)
    ) i_sample_capture (
        .clk        (clk),
        .rst        (rst),
        .in_strobe  (in_strobe),
        .l_in       (l_in),
        .r_in       (r_in),
        .phase_cnt  (phase_cnt),
        .busy       (busy),
        .l_new      (l_new),
        .l_old      (l_old),
        .r_new      (r_new),
        .r_old      (r_old),
        .phase_coef (phase_coef)
    );

    ////////////////////////////////////////////////////////////
    // interpolation, tick to sum_valid in 6 cycles
    ////////////////////////////////////////////////////////////

    interp_engine #(
        .PERIOD_LOG2 (PERIOD_LOG2)
    ) i_interp_engine (
        .clk        (clk),
        .rst        (rst),
        .tick       (tick),
        .l_new      (l_new),
        .l_old      (l_old),
        .r_new      (r_new),
        .r_old      (r_old),
        .phase_coef (phase_coef),
        .busy       (busy),
        .sum_valid  (sum_valid),
        .l_sum      (l_sum),
        .r_sum      (r_sum)
    );

    ////////////////////////////////////////////////////////////
    // output side
    ////////////////////////////////////////////////////////////

    output_stage #(
        .PERIOD_LOG2 (PERIOD_LOG2)
    ) i_output_stage (
        .clk       (clk),
        .rst       (rst),
        .run       (run),
        .tick      (tick),
        .phase_cnt (phase_cnt),
        .sum_valid (sum_valid),
        .l_sum     (l_sum),
        .r_sum     (r_sum),
        .out_valid (out_valid),   // tick + 7
        .l_out     (l_out),
        .r_out     (r_out)
    );

endmodule

/* bench/tb_checks.svh */
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

////////////////////////////////////////////////////////////
// error bookkeeping
////////////////////////////////////////////////////////////

int value_errors = 0;   // wrong sample, strobe or cycle count
int other_errors = 0;   // missing pulses, stalls

task automatic report_failure(input string msg);
    other_errors++;
    $display("%0t ns: %s", $time, msg);
endtask

task automatic check_sample(input string name, input src_pkg::sample_t got,
                            input src_pkg::sample_t exp);
    if (got !== exp) begin
        value_errors++;
        $display("[ERROR] %s got 0x%h expected 0x%h at %0t ns", name, got, exp, $time);
    end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        value_errors++;
        $display("[ERROR] %s got 0x%h expected 0x%h at %0t ns", name, got, exp, $time);
    end
endtask

task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
        value_errors++;
        $display("[ERROR] %s got 0x%0h expected 0x%0h at %0t ns", name, got, exp, $time);
    end
endtask

////////////////////////////////////////////////////////////
// reference interpolation
////////////////////////////////////////////////////////////

// newest weighted by period - phase, older by phase, round half up
function automatic src_pkg::sample_t ref_interp(input src_pkg::sample_t newer,
                                                input src_pkg::sample_t older,
                                                input int phase);
    longint period;
    longint acc;
    period = longint'(1) << PERIOD_LOG2;
    acc = longint'(newer) * (period - phase) + longint'(older) * phase;
    acc = acc + period / 2;                    // half an output lsb
    return src_pkg::sample_t'(acc >>> PERIOD_LOG2);   // floor division
endfunction

`endif

/* bench/tb_stereo_interp.sv */
`timescale 1ns/1ps

module tb_stereo_interp;

    localparam int PERIOD_LOG2 = 9;
    localparam int PERIOD      = 1 << PERIOD_LOG2;   // cycles per output sample
    localparam int CLK_NS      = 100;
    localparam int LATENCY     = 7;                  // tick to out_valid
    // output periods used by each test, in run order
    localparam int TEST_PERIODS = 3 + 8 + 5 + 5 + 4;
    localparam int WATCHDOG_NS  = (TEST_PERIODS + 4) * PERIOD * CLK_NS;

    logic             clk;
    logic             rst;
    logic             run;
    logic             in_strobe;
    src_pkg::sample_t l_in;
    src_pkg::sample_t r_in;
    logic             out_valid;
    src_pkg::sample_t l_out;
    src_pkg::sample_t r_out;

    `include "tb_checks.svh"

    stereo_interp_top #(
        .PERIOD_LOG2 (PERIOD_LOG2)
    ) i_stereo_interp_top (
        .clk       (clk),
        .rst       (rst),
        .run       (run),
        .in_strobe (in_strobe),
        .l_in      (l_in),
        .r_in      (r_in),
        .out_valid (out_valid),
        .l_out     (l_out),
        .r_out     (r_out)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, tests did not finish", WATCHDOG_NS);
        $display("** FAIL **");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // stimulus helpers, all start and end on a falling edge
    ////////////////////////////////////////////////////////////

    task automatic skip_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic strobe_sample(input src_pkg::sample_t l, input src_pkg::sample_t r);
        in_strobe = 1'b1;
        l_in      = l;
        r_in      = r;
        @(negedge clk);
        in_strobe = 1'b0;
    endtask

    // returns on the falling edge where out_valid is seen
    task automatic wait_out_valid(output int cycles);
        @(negedge clk);
        cycles = 1;
        while (!out_valid && cycles < PERIOD + 2 * LATENCY) begin
            @(negedge clk);
            cycles++;
        end
        if (!out_valid) report_failure($sformatf("no out_valid within %0d cycles", cycles));
    endtask

    // called at an out_valid edge, older at +1, newer at +k, ends at next out_valid
    task automatic strobe_pair(input src_pkg::sample_t l_older, input src_pkg::sample_t r_older,
                               input src_pkg::sample_t l_newer, input src_pkg::sample_t r_newer,
                               input int k);
        int cycles;
        skip_cycles(1);
        strobe_sample(l_older, r_older);
        skip_cycles(k - 2);
        strobe_sample(l_newer, r_newer);   // phase k + LATENCY
        wait_out_valid(cycles);
    endtask

    ////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////

    task automatic test_reset_idle();
        check_bit("out_valid", out_valid, 1'b0);
        repeat (3 * PERIOD) begin   // run low, divider held
            @(negedge clk);
            check_bit("out_valid", out_valid, 1'b0);
        end
    endtask

    task automatic test_output_rate();
        int cycles;
        int pulses;
        int i;
        run = 1'b1;
        wait_out_valid(cycles);
        check_count("first out_valid delay", cycles, PERIOD + LATENCY);
        repeat (3) begin
            wait_out_valid(cycles);
            check_count("out_valid interval", cycles, PERIOD);
        end
        skip_cycles(PERIOD - 5);   // tick already out, engine mid pass
        run    = 1'b0;
        pulses = 0;
        for (i = 1; i <= 2 * PERIOD; i++) begin
            @(negedge clk);
            if (out_valid) begin
                pulses++;
                if (i > LATENCY) report_failure($sformatf("out_valid %0d cycles after run low", i));
            end
        end
        check_count("out_valid pulses after run low", pulses, 1);
    endtask

    task automatic test_constant_input();
        int               cycles;
        src_pkg::sample_t lv;
        src_pkg::sample_t rv;
        run = 1'b1;
        wait_out_valid(cycles);   // sync to the output grid
        repeat (3) begin
            lv = src_pkg::sample_t'($urandom());
            rv = src_pkg::sample_t'($urandom());
            strobe_pair(lv, rv, lv, rv, 3 + $urandom() % (PERIOD - 16));
            check_sample("l_out", l_out, lv);   // exact, weights sum to period
            check_sample("r_out", r_out, rv);
        end
    endtask

    task automatic test_interpolated_value();
        int               cycles;
        int               i;
        int               k;
        src_pkg::sample_t lo;
        src_pkg::sample_t ro;
        src_pkg::sample_t ln;
        src_pkg::sample_t rn;
        wait_out_valid(cycles);
        for (i = 0; i < 4; i++) begin
            if (i == 0) begin   // full scale swing, opposite on each channel
                lo = src_pkg::sample_t'(24'h800000);
                ln = src_pkg::sample_t'(24'h7fffff);
                ro = ln;
                rn = lo;
            end else begin
                lo = src_pkg::sample_t'($urandom());
                ln = src_pkg::sample_t'($urandom());
                ro = src_pkg::sample_t'($urandom());
                rn = src_pkg::sample_t'($urandom());
            end
            k = 2 + $urandom() % (PERIOD - 12);
            strobe_pair(lo, ro, ln, rn, k);
            check_sample("l_out", l_out, ref_interp(ln, lo, k + LATENCY));
            check_sample("r_out", r_out, ref_interp(rn, ro, k + LATENCY));
        end
    endtask

    task automatic test_deferred_commit();
        int               cycles;
        src_pkg::sample_t la;
        src_pkg::sample_t ra;
        src_pkg::sample_t lb;
        src_pkg::sample_t rb;
        src_pkg::sample_t lc;
        src_pkg::sample_t rc;
        la = src_pkg::sample_t'($urandom());
        ra = src_pkg::sample_t'($urandom());
        lb = src_pkg::sample_t'($urandom());
        rb = src_pkg::sample_t'($urandom());
        lc = src_pkg::sample_t'($urandom());
        rc = src_pkg::sample_t'($urandom());
        wait_out_valid(cycles);
        strobe_pair(la, ra, lb, rb, 3);   // history b over a, phase 10
        check_sample("l_out", l_out, ref_interp(lb, la, 10));
        check_sample("r_out", r_out, ref_interp(rb, ra, 10));
        skip_cycles(PERIOD - 5);          // 2 cycles after tick, engine busy
        strobe_sample(lc, rc);
        wait_out_valid(cycles);
        check_count("deferred strobe to out_valid", cycles, 4);
        check_sample("l_out", l_out, ref_interp(lb, la, 10));   // c held back
        check_sample("r_out", r_out, ref_interp(rb, ra, 10));
        wait_out_valid(cycles);
        check_sample("l_out", l_out, ref_interp(lc, lb, 2));
        check_sample("r_out", r_out, ref_interp(rc, rb, 2));
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        void'($urandom(32'h2198f86c));
        rst       = 1'b1;
        run       = 1'b0;
        in_strobe = 1'b0;
        l_in      = '0;
        r_in      = '0;
        repeat (10) @(negedge clk);
        rst = 1'b0;

        test_reset_idle();
        test_output_rate();
        test_constant_input();
        test_interpolated_value();
        test_deferred_commit();

        $display("tests done: %0d value errors, %0d other failures", value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* stereo_interp_top.f */
+incdir+bench
common/src_pkg.sv
rtl/sample_capture.sv
interp/tap_multiplier.sv
interp/interp_engine.sv
rtl/output_stage.sv
rtl/stereo_interp_top.sv
bench/tb_stereo_interp.sv

/* Bender.yml */
package:
  name: stereo_interp

sources:
  - common/src_pkg.sv
  - rtl/sample_capture.sv
  - interp/tap_multiplier.sv
  - interp/interp_engine.sv
  - rtl/output_stage.sv
  - rtl/stereo_interp_top.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/tb_stereo_interp.sv
